// ==== logic/timer_pkg.sv ====
`default_nettype none

package timer_pkg;

    // ##################################################
    // Bus types
    // ##################################################

    typedef logic [31:0] word_t;                        // Bus data word
    typedef logic [5:0]  addr_t;                        // Register address
    typedef logic [31:0] count_t;                       // Prescaler, reload and counts

    localparam int unsigned DEFAULT_CLK_FREQ   = 50_000_000;  // Hz, used at prescaler all ones
    localparam int unsigned DEFAULT_FIFO_DEPTH = 4;

    // ##################################################
    // Timer block, 0x00 to 0x1F
    // ##################################################

    localparam addr_t TIM_PRE_ADDR = 6'h00;             // Prescaler, sub-word views at +1..+3
    localparam addr_t TIM_ARE_ADDR = 6'h04;             // Auto-reload limit
    localparam addr_t TIM_CLR_ADDR = 6'h08;             // Count clear level
    localparam addr_t TIM_ENA_ADDR = 6'h0C;
    localparam addr_t TIM_MOD_ADDR = 6'h10;             // 1 up, 0 down
    localparam addr_t TIM_CNT_ADDR = 6'h14;
    localparam addr_t TIM_EVN_ADDR = 6'h18;             // Event count
    localparam addr_t TIM_EVC_ADDR = 6'h1C;             // Event count clear level

    // ##################################################
    // Interrupt block, 0x20 to 0x3F
    // ##################################################

    localparam addr_t IRQ_CTRL_ADDR = 6'h20;            // Bit 0 enable
    localparam addr_t IRQ_STAT_ADDR = 6'h24;            // Bit 0 not empty, bit 1 overflow
    localparam addr_t IRQ_DATA_ADDR = 6'h28;            // Head record, read_i pops

endpackage

`default_nettype wire

// ==== logic/timer_core.sv ====
`default_nettype none

module timer_core
    import timer_pkg::*;
#(
    parameter int unsigned CLK_FREQ = DEFAULT_CLK_FREQ
) (
    input  wire         clk_i,
    input  wire         rst_i,
    input  wire         write_i,
    input  wire [3:0]   data_be_i,                      // Unused, sub-word registers give byte access
    input  wire [4:0]   addr_i,
    input  wire word_t  wdata_i,
    output word_t       rdata_o,
    output logic        evt_push_o,
    output count_t      evt_value_o
);

    count_t tim_pre, pre_nxt;
    count_t tim_are, are_nxt;
    logic   tim_clr, clr_nxt;
    logic   tim_ena, ena_nxt;
    logic   tim_mod, mod_nxt;
    count_t tim_cnt, cnt_nxt;
    count_t tim_evn, evn_nxt;
    logic   tim_evc, evc_nxt;
    count_t counter, counter_nxt;                       // Prescaler divider
    count_t condition, condition_nxt;                   // Divider terminal value
    logic   push_nxt;

    addr_t       base;
    logic [1:0]  offset;
    logic        aligned;
    logic        step;
    logic        reload;

    assign base    = {1'b0, addr_i[4:2], 2'b00};
    assign offset  = addr_i[1:0];
    assign aligned = (offset == 2'd0);

    // Byte or half-word view moved to the low end
    function automatic word_t view_read(count_t value, logic [1:0] sel);
        word_t result;
        result = '0;
        case (sel)
            2'd0:    result = value;
            2'd1:    result[7:0] = value[15:8];
            2'd2:    result[15:0] = value[31:16];
            default: result[7:0] = value[31:24];
        endcase
        return result;
    endfunction

    function automatic count_t view_write(count_t value, logic [1:0] sel, word_t data);
        count_t result;
        result = value;
        case (sel)
            2'd0:    result = data;
            2'd1:    result[15:8] = data[7:0];
            2'd2:    result[31:16] = data[15:0];
            default: result[31:24] = data[7:0];
        endcase
        return result;
    endfunction

    // ##################################################
    // Register writes and counting
    // ##################################################

    always_comb begin
        pre_nxt     = tim_pre;
        are_nxt     = tim_are;
        clr_nxt     = tim_clr;
        ena_nxt     = tim_ena;
        mod_nxt     = tim_mod;
        cnt_nxt     = tim_cnt;
        evn_nxt     = tim_evn;
        evc_nxt     = tim_evc;
        counter_nxt = counter;

        if (write_i) begin
            case (base)
                TIM_PRE_ADDR: pre_nxt = view_write(tim_pre, offset, wdata_i);
                TIM_ARE_ADDR: are_nxt = view_write(tim_are, offset, wdata_i);
                TIM_CLR_ADDR: begin
                    if (aligned) clr_nxt = wdata_i[0];
                end
                TIM_ENA_ADDR: begin
                    if (aligned) ena_nxt = wdata_i[0];
                end
                TIM_MOD_ADDR: begin
                    if (aligned) mod_nxt = wdata_i[0];
                end
                TIM_EVC_ADDR: begin
                    if (aligned) evc_nxt = wdata_i[0];
                end
                default: ;
            endcase
        end

        condition_nxt = (&pre_nxt) ? count_t'(CLK_FREQ - 1) : pre_nxt;

        if (step) begin
            counter_nxt = '0;
            if (reload) begin
                cnt_nxt = '0;
                evn_nxt = tim_evn + 1'b1;
            end else if (tim_mod) begin
                cnt_nxt = tim_cnt + 1'b1;
            end else begin
                cnt_nxt = tim_cnt - 1'b1;
            end
        end else begin
            counter_nxt = counter + 1'b1;
        end

        if (tim_clr) cnt_nxt = '0;                      // Clear levels override counting
        if (tim_evc) evn_nxt = '0;

        push_nxt = reload & ~tim_evc;
    end

    // >= so a smaller prescaler takes effect without a full wrap
    assign step   = tim_ena & (counter >= condition);
    assign reload = step & (tim_are == tim_cnt);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            tim_pre    <= '1;
            tim_are    <= '1;
            tim_clr    <= 1'b0;
            tim_ena    <= 1'b1;
            tim_mod    <= 1'b0;
            tim_cnt    <= '0;
            tim_evn    <= '0;
            tim_evc    <= 1'b0;
            counter    <= '0;
            condition  <= count_t'(CLK_FREQ - 1);
            evt_push_o <= 1'b0;
        end else begin
            tim_pre    <= pre_nxt;
            tim_are    <= are_nxt;
            tim_clr    <= clr_nxt;
            tim_ena    <= ena_nxt;
            tim_mod    <= mod_nxt;
            tim_cnt    <= cnt_nxt;
            tim_evn    <= evn_nxt;
            tim_evc    <= evc_nxt;
            counter    <= counter_nxt;
            condition  <= condition_nxt;
            evt_push_o <= push_nxt;                     // High while tim_evn shows the new count
        end
    end

    assign evt_value_o = tim_evn;

    // ##################################################
    // Read mux
    // ##################################################

    always_comb begin
        rdata_o = '0;
        case (base)
            TIM_PRE_ADDR: rdata_o = view_read(tim_pre, offset);
            TIM_ARE_ADDR: rdata_o = view_read(tim_are, offset);
            TIM_CLR_ADDR: rdata_o[0] = aligned & tim_clr;
            TIM_ENA_ADDR: rdata_o[0] = aligned & tim_ena;
            TIM_MOD_ADDR: rdata_o[0] = aligned & tim_mod;
            TIM_CNT_ADDR: rdata_o = view_read(tim_cnt, offset);
            TIM_EVN_ADDR: rdata_o = view_read(tim_evn, offset);
            TIM_EVC_ADDR: rdata_o[0] = aligned & tim_evc;
            default:      rdata_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/event_fifo.sv ====
`default_nettype none

module event_fifo
    import timer_pkg::*;
#(
    parameter int unsigned DEPTH = DEFAULT_FIFO_DEPTH,
    parameter int unsigned WIDTH = $bits(count_t)
) (
    input  wire             clk_i,
    input  wire             rst_i,
    input  wire             push_i,
    input  wire [WIDTH-1:0] data_i,
    input  wire             pop_i,
    output logic [WIDTH-1:0] head_o,
    output logic            not_empty_o,
    output logic            drop_o
);

    localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(DEPTH + 1);
    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);
    localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(DEPTH);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             do_push;
    logic             do_pop;

    assign full        = (count == FULL_CNT);
    assign not_empty_o = (count != '0);
    assign do_push     = push_i & ~full;
    assign do_pop      = pop_i & not_empty_o;
    assign drop_o      = push_i & full;                 // Record lost
    assign head_o      = mem[rd_ptr];

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem[wr_ptr] <= data_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;                // Both or neither
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/irq_unit.sv ====
`default_nettype none

module irq_unit
    import timer_pkg::*;
(
    input  wire         clk_i,
    input  wire         rst_i,
    input  wire         write_i,
    input  wire         read_i,
    input  wire addr_t  addr_i,
    input  wire word_t  wdata_i,
    input  wire count_t head_i,
    input  wire         not_empty_i,
    input  wire         drop_i,
    output word_t       rdata_o,
    output logic        pop_o,
    output logic        irq_o
);

    logic irq_en;
    logic overflow;                                     // Sticky until status write
    logic ctrl_wr;
    logic stat_wr;

    assign ctrl_wr = write_i & (addr_i == IRQ_CTRL_ADDR);
    assign stat_wr = write_i & (addr_i == IRQ_STAT_ADDR);
    assign pop_o   = read_i & (addr_i == IRQ_DATA_ADDR) & not_empty_i;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            irq_en   <= 1'b0;
            overflow <= 1'b0;
            irq_o    <= 1'b0;
        end else begin
            if (ctrl_wr) begin
                irq_en <= wdata_i[0];
            end
            if (drop_i) begin
                overflow <= 1'b1;                       // New drop wins over clear
            end else if (stat_wr) begin
                overflow <= 1'b0;
            end
            irq_o <= irq_en & not_empty_i;              // Level while records wait
        end
    end

    // ##################################################
    // Read mux
    // ##################################################

    always_comb begin
        rdata_o = '0;
        case (addr_i)
            IRQ_CTRL_ADDR: rdata_o[0] = irq_en;
            IRQ_STAT_ADDR: begin
                rdata_o[0] = not_empty_i;
                rdata_o[1] = overflow;
            end
            IRQ_DATA_ADDR: begin
                if (not_empty_i) rdata_o = head_i;      // Zero when empty
            end
            default:       rdata_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/periph_bus.sv ====
`default_nettype none

module periph_bus
    import timer_pkg::*;
(
    input  wire addr_t  addr_i,
    input  wire         write_i,
    input  wire         read_i,
    input  wire word_t  tim_rdata_i,
    input  wire word_t  irq_rdata_i,
    output logic        tim_write_o,
    output logic        irq_write_o,
    output logic        irq_read_o,
    output word_t       rdata_o
);

    logic irq_sel;

    // Upper half of the map belongs to the interrupt block
    assign irq_sel = addr_i[5];

    assign tim_write_o = write_i & ~irq_sel;
    assign irq_write_o = write_i & irq_sel;
    assign irq_read_o  = read_i & irq_sel;              // Timer reads have no side effect

    assign rdata_o = irq_sel ? irq_rdata_i : tim_rdata_i;

endmodule

`default_nettype wire

// ==== logic/timer_subsystem.sv ====
`default_nettype none

module timer_subsystem
    import timer_pkg::*;
#(
    parameter int unsigned CLK_FREQ   = DEFAULT_CLK_FREQ,
    parameter int unsigned FIFO_DEPTH = DEFAULT_FIFO_DEPTH
) (
    input  wire         clk_i,
    input  wire         rst_i,
    input  wire         write_i,
    input  wire         read_i,
    input  wire addr_t  addr_i,
    input  wire word_t  wdata_i,
    input  wire [3:0]   data_be_i,
    output word_t       rdata_o,
    output logic        irq_o
);

    logic   tim_write;
    logic   irq_write;
    logic   irq_read;
    word_t  tim_rdata;
    word_t  irq_rdata;
    logic   evt_push;
    count_t evt_value;
    count_t fifo_head;
    logic   fifo_not_empty;
    logic   fifo_drop;
    logic   fifo_pop;

    periph_bus u_bus (
        .addr_i      (addr_i),
        .write_i     (write_i),
        .read_i      (read_i),
        .tim_rdata_i (tim_rdata),
        .irq_rdata_i (irq_rdata),
        .tim_write_o (tim_write),
        .irq_write_o (irq_write),
        .irq_read_o  (irq_read),
        .rdata_o     (rdata_o)
    );

    timer_core #(
        .CLK_FREQ (CLK_FREQ)
    ) u_timer (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .write_i     (tim_write),
        .data_be_i   (data_be_i),
        .addr_i      (addr_i[4:0]),
        .wdata_i     (wdata_i),
        .rdata_o     (tim_rdata),
        .evt_push_o  (evt_push),
        .evt_value_o (evt_value)
    );

    event_fifo #(
        .DEPTH (FIFO_DEPTH),
        .WIDTH ($bits(count_t))
    ) u_fifo (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .push_i      (evt_push),
        .data_i      (evt_value),
        .pop_i       (fifo_pop),
        .head_o      (fifo_head),
        .not_empty_o (fifo_not_empty),
        .drop_o      (fifo_drop)
    );

    irq_unit u_irq (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .write_i     (irq_write),
        .read_i      (irq_read),
        .addr_i      (addr_i),
        .wdata_i     (wdata_i),
        .head_i      (fifo_head),
        .not_empty_i (fifo_not_empty),
        .drop_i      (fifo_drop),
        .rdata_o     (irq_rdata),
        .pop_o       (fifo_pop),
        .irq_o       (irq_o)
    );

endmodule

`default_nettype wire

// ==== test/timer_tb_table.svh ====
task automatic load_table();
    // Reset values
    add_row(OP_RD, TIM_PRE_ADDR, 0, 32'hffff_ffff, "rst_pre");
    add_row(OP_RD, TIM_ARE_ADDR, 0, 32'hffff_ffff, "rst_are");
    add_row(OP_RD, TIM_CLR_ADDR, 0, 0, "rst_clr");
    add_row(OP_RD, TIM_ENA_ADDR, 0, 1, "rst_ena");
    add_row(OP_RD, TIM_MOD_ADDR, 0, 0, "rst_mod");
    add_row(OP_RD, TIM_CNT_ADDR, 0, 0, "rst_cnt");
    add_row(OP_RD, TIM_EVN_ADDR, 0, 0, "rst_evn");
    add_row(OP_RD, TIM_EVC_ADDR, 0, 0, "rst_evc");
    add_row(OP_RD, IRQ_CTRL_ADDR, 0, 0, "rst_irq_ctrl");
    add_row(OP_RD, IRQ_STAT_ADDR, 0, 0, "rst_irq_stat");
    add_row(OP_IRQ, 0, 0, 0, "rst_irq_line");
    // Whole word and sub-word views
    add_row(OP_WRR, TIM_PRE_ADDR, 0, 0, "pre_write");
    add_row(OP_RDR, 6'h00, 0, 0, "pre_view0");
    add_row(OP_RDR, 6'h01, 0, 0, "pre_view1");
    add_row(OP_RDR, 6'h02, 0, 0, "pre_view2");
    add_row(OP_RDR, 6'h03, 0, 0, "pre_view3");
    add_row(OP_WRR, TIM_ARE_ADDR, 1, 0, "are_write");
    add_row(OP_RDR, 6'h04, 1, 0, "are_view0");
    add_row(OP_RDR, 6'h05, 1, 0, "are_view1");
    add_row(OP_RDR, 6'h06, 1, 0, "are_view2");
    add_row(OP_RDR, 6'h07, 1, 0, "are_view3");
    // Counting
    add_row(OP_WR, TIM_ENA_ADDR, 0, 0, "cnt_stop");
    add_row(OP_WR, TIM_CLR_ADDR, 1, 0, "cnt_clr_on");
    add_row(OP_WR, TIM_CLR_ADDR, 0, 0, "cnt_clr_off");
    add_row(OP_RD, TIM_CNT_ADDR, 0, 0, "cnt_start");
    add_row(OP_WR, TIM_PRE_ADDR, 1, 0, "cnt_pre");
    add_row(OP_WR, TIM_ARE_ADDR, 1000, 0, "cnt_are");
    add_row(OP_WAIT, 0, 10, 0, "cnt_wait");
    add_row(OP_RD, TIM_CNT_ADDR, 0, 0, "cnt_hold");
    add_row(OP_WR, TIM_MOD_ADDR, 1, 0, "cnt_mode_up");
    add_row(OP_WR, TIM_ENA_ADDR, 1, 0, "cnt_run");
    add_row(OP_WAIT, 0, 10, 0, "cnt_wait_up");
    add_row(OP_WR, TIM_ENA_ADDR, 0, 0, "cnt_stop_up");
    add_row(OP_RDRNG, TIM_CNT_ADDR, 5, 6, "cnt_up");  // Eleven enabled cycles, step every two
    add_row(OP_WR, TIM_CLR_ADDR, 1, 0, "cnt_clr_on");
    add_row(OP_WR, TIM_CLR_ADDR, 0, 0, "cnt_clr_off");
    add_row(OP_WR, TIM_MOD_ADDR, 0, 0, "cnt_mode_down");
    add_row(OP_WR, TIM_ENA_ADDR, 1, 0, "cnt_run");
    add_row(OP_WAIT, 0, 4, 0, "cnt_wait_down");
    add_row(OP_WR, TIM_ENA_ADDR, 0, 0, "cnt_stop_down");
    add_row(OP_RDRNG, TIM_CNT_ADDR, 32'hffff_fffd, 32'hffff_fffe, "cnt_down");  // Wrapped below zero
    add_row(OP_WR, TIM_CLR_ADDR, 1, 0, "cnt_clr_on");
    add_row(OP_WAIT, 0, 1, 0, "cnt_clr_wait");
    add_row(OP_RD, TIM_CNT_ADDR, 0, 0, "cnt_clr");
    add_row(OP_WR, TIM_CLR_ADDR, 0, 0, "cnt_clr_off");
    // Reload, events, then overflow
    add_row(OP_WR, TIM_EVC_ADDR, 1, 0, "evt_clr_on");
    add_row(OP_WR, TIM_EVC_ADDR, 0, 0, "evt_clr_off");
    add_row(OP_WR, TIM_PRE_ADDR, 0, 0, "evt_pre");
    add_row(OP_WR, TIM_ARE_ADDR, 3, 0, "evt_are");
    add_row(OP_WR, TIM_MOD_ADDR, 1, 0, "evt_mode");
    add_row(OP_WR, IRQ_CTRL_ADDR, 1, 0, "evt_irq_on");
    add_row(OP_WR, TIM_ENA_ADDR, 1, 0, "evt_run");
    add_row(OP_POLL, 0, 50, 0, "evt_poll");
    add_row(OP_RD, IRQ_DATA_ADDR, 0, 1, "evt_data");
    add_row(OP_RDRNG, TIM_EVN_ADDR, 1, 32'hffff_ffff, "evt_count");
    add_row(OP_WAIT, 0, 20, 0, "ovf_wait");        // Well past four events
    add_row(OP_WR, TIM_ENA_ADDR, 0, 0, "ovf_stop");
    add_row(OP_WR, IRQ_CTRL_ADDR, 0, 0, "ovf_irq_off");
    add_row(OP_RD, IRQ_STAT_ADDR, 0, 3, "ovf_stat");
    add_row(OP_POP, IRQ_DATA_ADDR, 0, 1, "ovf_pop1");
    add_row(OP_POP, IRQ_DATA_ADDR, 0, 2, "ovf_pop2");
    add_row(OP_POP, IRQ_DATA_ADDR, 0, 3, "ovf_pop3");
    add_row(OP_POP, IRQ_DATA_ADDR, 0, 4, "ovf_pop4");
    add_row(OP_RD, IRQ_STAT_ADDR, 0, 2, "ovf_empty");
    add_row(OP_WR, IRQ_STAT_ADDR, 0, 0, "ovf_clear");
    add_row(OP_RD, IRQ_STAT_ADDR, 0, 0, "ovf_cleared");
    // Exactly three events, reloads at 4, 8 and 12 cycles after enable
    add_row(OP_WR, TIM_EVC_ADDR, 1, 0, "fifo_evc_on");
    add_row(OP_WR, TIM_EVC_ADDR, 0, 0, "fifo_evc_off");
    add_row(OP_WR, TIM_CLR_ADDR, 1, 0, "fifo_clr_on");
    add_row(OP_WR, TIM_CLR_ADDR, 0, 0, "fifo_clr_off");
    add_row(OP_WR, TIM_ENA_ADDR, 1, 0, "fifo_run");
    add_row(OP_WAIT, 0, 12, 0, "fifo_wait");
    add_row(OP_WR, TIM_ENA_ADDR, 0, 0, "fifo_stop");
    add_row(OP_RD, IRQ_STAT_ADDR, 0, 1, "fifo_stat");
    add_row(OP_IRQ, 0, 0, 0, "fifo_irq_masked");
    add_row(OP_WR, IRQ_CTRL_ADDR, 1, 0, "fifo_irq_on");
    add_row(OP_WAIT, 0, 2, 0, "fifo_irq_wait");
    add_row(OP_IRQ, 0, 0, 1, "fifo_irq_high");
    add_row(OP_POP, IRQ_DATA_ADDR, 0, 1, "fifo_pop1");
    add_row(OP_POP, IRQ_DATA_ADDR, 0, 2, "fifo_pop2");
    add_row(OP_POP, IRQ_DATA_ADDR, 0, 3, "fifo_pop3");
    add_row(OP_RD, IRQ_STAT_ADDR, 0, 0, "fifo_empty");
    add_row(OP_WAIT, 0, 2, 0, "fifo_irq_settle");
    add_row(OP_IRQ, 0, 0, 0, "fifo_irq_low");
endtask

// ==== test/timer_tb.sv ====
`default_nettype none

module timer_tb
    import timer_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int OP_WR    = 0;
    localparam int OP_WRR   = 1;                        // Write random slot
    localparam int OP_RD    = 2;
    localparam int OP_RDR   = 3;                        // Read view of random slot
    localparam int OP_RDRNG = 4;                        // Read, value from data up to exp
    localparam int OP_POP   = 5;
    localparam int OP_IRQ   = 6;
    localparam int OP_WAIT  = 7;
    localparam int OP_POLL  = 8;

    logic       clk_i;
    logic       rst_i;
    logic       write_i;
    logic       read_i;
    addr_t      addr_i;
    word_t      wdata_i;
    logic [3:0] data_be_i;
    word_t      rdata_o;
    logic       irq_o;

    int    op_q[$];
    addr_t addr_q[$];
    word_t data_q[$];
    word_t exp_q[$];
    string name_q[$];
    word_t rnd[2];
    int unsigned limit = 0;
    int unsigned cycles = 0;

    timer_subsystem #(
        .CLK_FREQ   (DEFAULT_CLK_FREQ),
        .FIFO_DEPTH (4)
    ) uut (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .write_i   (write_i),
        .read_i    (read_i),
        .addr_i    (addr_i),
        .wdata_i   (wdata_i),
        .data_be_i (data_be_i),
        .rdata_o   (rdata_o),
        .irq_o     (irq_o)
    );

    task automatic add_row(int op, addr_t addr, word_t data, word_t exp, string name);
        op_q.push_back(op);
        addr_q.push_back(addr);
        data_q.push_back(data);
        exp_q.push_back(exp);
        name_q.push_back(name);
    endtask

    `include "timer_tb_table.svh"

    task automatic check(string name, word_t exp, word_t act);
        if (exp !== act) begin
            $display("Error %s: expected %h, actual %h", name, exp, act);
            $display("RESULT: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    // Offset n puts the part starting at byte n at the low end
    function automatic word_t expected_view(word_t value, logic [1:0] off);
        word_t shifted;
        shifted = value >> (8 * off);
        if (off == 2'd0) return shifted;
        if (off == 2'd2) return shifted & 32'h0000_ffff;
        return shifted & 32'h0000_00ff;
    endfunction

    // ##################################################
    // Row execution
    // ##################################################

    task automatic run_row(int i);
        word_t d;
        int    n;
        @(posedge clk_i);
        #2;
        write_i = 1'b0;
        read_i  = 1'b0;
        addr_i  = addr_q[i];
        case (op_q[i])
            OP_WR: begin
                wdata_i = data_q[i];
                write_i = 1'b1;
            end
            OP_WRR: begin
                wdata_i = rnd[data_q[i][0]];
                write_i = 1'b1;
            end
            OP_RD: begin
                #1;
                check(name_q[i], exp_q[i], rdata_o);
            end
            OP_RDR: begin
                #1;
                check(name_q[i], expected_view(rnd[data_q[i][0]], addr_q[i][1:0]), rdata_o);
            end
            OP_RDRNG: begin
                #1;
                d = rdata_o;
                check(name_q[i], exp_q[i], (d >= data_q[i] && d <= exp_q[i]) ? exp_q[i] : d);
            end
            OP_POP: begin
                read_i = 1'b1;
                #1;
                check(name_q[i], exp_q[i], rdata_o);
            end
            OP_IRQ: check(name_q[i], exp_q[i], {31'b0, irq_o});
            OP_WAIT: begin
                if (data_q[i] > 1) repeat (data_q[i] - 1) @(posedge clk_i);
            end
            OP_POLL: begin
                n = 0;
                while (!irq_o && n < data_q[i]) begin
                    @(posedge clk_i);
                    #2;
                    n++;
                end
                if (!irq_o) begin
                    $display("Interrupt never came within %0d cycles in %s", data_q[i], name_q[i]);
                    $display("RESULT: FAIL");
                    $fatal(1, "poll ran out");
                end
            end
            default: ;
        endcase
    endtask

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycles++;
        if (limit != 0 && cycles > limit) begin
            $display("Timeout, the test table did not finish within %0d cycles", limit);
            $display("RESULT: FAIL");
            $fatal(1, "timeout");
        end
    end

    initial begin
        void'($urandom(32'hcd09));
        rst_i     = 1'b1;
        write_i   = 1'b0;
        read_i    = 1'b0;
        addr_i    = '0;
        wdata_i   = '0;
        data_be_i = 4'hf;
        rnd[0]    = $urandom;
        rnd[1]    = $urandom;
        load_table();
        limit = 8 + 100 + 2 * op_q.size();              // Reset, margin, one edge per row
        foreach (op_q[i]) begin
            if (op_q[i] == OP_WAIT || op_q[i] == OP_POLL) limit += data_q[i];
        end
        repeat (8) @(posedge clk_i);
        #2;
        rst_i = 1'b0;
        foreach (op_q[i]) run_row(i);
        @(posedge clk_i);
        #2;
        write_i = 1'b0;
        read_i  = 1'b0;
        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+test
logic/timer_pkg.sv
logic/timer_core.sv
logic/event_fifo.sv
logic/irq_unit.sv
logic/periph_bus.sv
logic/timer_subsystem.sv
test/timer_tb.sv
